// File: dv/openmips_vectors.txt
# i <addr> <word> : program word   w <pc> <reg> <data> : expected writeback
# m <addr> <word> : expected memory word at the end
i 00 3c011234
i 04 34215678
i 08 24020100
i 0c 2403fffd
i 10 00622021
i 14 00242823
i 18 00a13024
i 1c 00c33826
i 20 0062402a
i 24 01024825
i 28 ac410000
i 2c a0490005
i 30 a0470002
i 34 8c4a0000
i 38 01485821
i 3c 8c4c0004
i 40 11890002
i 44 240d0001
i 48 15890002
i 4c 240e0002
i 50 240f0077
i 54 11ce0002
i 58 24100003
i 5c 240f0099
i 60 0800001c
i 64 020d8821
i 68 240f0055
i 6c 240f0066
i 70 ac510008
i 74 0800001d
i 78 00000000
w 00 01 12340000
w 04 01 12345678
w 08 02 00000100
w 0c 03 fffffffd
w 10 04 000000fd
w 14 05 1234557b
w 18 06 12345478
w 1c 07 edcbab85
w 20 08 00000001
w 24 09 00000101
w 34 0a 12855678
w 38 0b 12855679
w 3c 0c 00000100
w 44 0d 00000001
w 4c 0e 00000002
w 58 10 00000003
w 64 11 00000004
m 100 12855678
m 104 00000100
m 108 00000004

// File: compile.f
source/mips_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/core_ifs.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/bus_arbiter.sv
source/openmips_core.sv
dv/tb_openmips.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -f compile.f --top-module tb_openmips -o tb_openmips \
	&& ./obj_dir/tb_openmips \
	|| exit 1

// File: dv/tb_openmips.sv
module tb_openmips;

	localparam int MEM_WORDS = 1024;

	logic                            clk;
	logic                            rst_n_i;
	logic [cpu_pipe_pkg::WORD_W-1:0] mem_rdata;
	logic                            mem_en;
	logic [cpu_pipe_pkg::BE_W-1:0]   mem_wen;
	logic [cpu_pipe_pkg::WORD_W-1:0] mem_addr;
	logic [cpu_pipe_pkg::WORD_W-1:0] mem_wdata;
	logic [cpu_pipe_pkg::WORD_W-1:0] dbg_pc;
	logic [cpu_pipe_pkg::BE_W-1:0]   dbg_wen;
	logic [cpu_pipe_pkg::REG_AW-1:0] dbg_wnum;
	logic [cpu_pipe_pkg::WORD_W-1:0] dbg_wdata;

	logic [cpu_pipe_pkg::WORD_W-1:0] mem [MEM_WORDS];
	logic [cpu_pipe_pkg::WORD_W-1:0] exp_wb_pc [$];
	logic [cpu_pipe_pkg::REG_AW-1:0] exp_wb_num [$];
	logic [cpu_pipe_pkg::WORD_W-1:0] exp_wb_data [$];
	logic [cpu_pipe_pkg::WORD_W-1:0] exp_mem_addr [$];
	logic [cpu_pipe_pkg::WORD_W-1:0] exp_mem_data [$];
	int                              wb_idx;
	int                              cycles;
	int                              limit;

	openmips_core #(.RESET_PC(32'h0)) u_openmips_core (
		.clk(clk), .rst_n_i(rst_n_i), .mem_rdata_i(mem_rdata), .mem_en_o(mem_en),
		.mem_wen_o(mem_wen), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
		.debug_wb_pc_o(dbg_pc), .debug_wb_rf_wen_o(dbg_wen),
		.debug_wb_rf_wnum_o(dbg_wnum), .debug_wb_rf_wdata_o(dbg_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// unified memory with same-cycle read
	assign mem_rdata = mem[mem_addr[11:2]];

	always @(posedge clk) begin
		if (mem_en) begin
			for (int i = 0; i < cpu_pipe_pkg::BE_W; i++) begin
				if (mem_wen[i])
					mem[mem_addr[11:2]][i*8 +: 8] <= mem_wdata[i*8 +: 8];
			end
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic read_vectors();
		int                              fd;
		int                              code;
		string                           tag;
		string                           rest;
		logic [cpu_pipe_pkg::WORD_W-1:0] a;
		logic [cpu_pipe_pkg::WORD_W-1:0] b;
		logic [cpu_pipe_pkg::WORD_W-1:0] c;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] <= '0;
		fd = $fopen("dv/openmips_vectors.txt", "r");
		if (fd == 0)
			abort_run("cannot open dv/openmips_vectors.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %s", tag);
			if (code != 1)
				break;
			if (tag == "#") begin
				code = $fgets(rest, fd); // comment line
			end else if (tag == "i") begin
				code = $fscanf(fd, "%h %h", a, b);
				mem[a[11:2]] <= b;
			end else if (tag == "w") begin
				code = $fscanf(fd, "%h %h %h", a, b, c);
				exp_wb_pc.push_back(a);
				exp_wb_num.push_back(b[cpu_pipe_pkg::REG_AW-1:0]);
				exp_wb_data.push_back(c);
			end else if (tag == "m") begin
				code = $fscanf(fd, "%h %h", a, b);
				exp_mem_addr.push_back(a);
				exp_mem_data.push_back(b);
			end else begin
				abort_run($sformatf("unknown line kind '%s' in vectors file", tag));
			end
		end
		$fclose(fd);
	endtask

	task automatic check_wb(
		input logic [cpu_pipe_pkg::BE_W-1:0]   wen,
		input logic [cpu_pipe_pkg::WORD_W-1:0] pc,
		input logic [cpu_pipe_pkg::REG_AW-1:0] num,
		input logic [cpu_pipe_pkg::WORD_W-1:0] data
	);
		if (wb_idx >= exp_wb_pc.size())
			abort_run($sformatf("unexpected extra register writeback at time %0t", $time));
		else if (wen !== {cpu_pipe_pkg::BE_W{1'b1}})
			abort_run($sformatf("mismatch at %0t: debug_wb_rf_wen_o got %b expected %b",
				$time, wen, {cpu_pipe_pkg::BE_W{1'b1}}));
		else if (pc !== exp_wb_pc[wb_idx])
			abort_run($sformatf("mismatch at %0t: debug_wb_pc_o got %h expected %h",
				$time, pc, exp_wb_pc[wb_idx]));
		else if (num !== exp_wb_num[wb_idx])
			abort_run($sformatf("mismatch at %0t: debug_wb_rf_wnum_o got %0d expected %0d",
				$time, num, exp_wb_num[wb_idx]));
		else if (data !== exp_wb_data[wb_idx])
			abort_run($sformatf("mismatch at %0t: debug_wb_rf_wdata_o got %h expected %h",
				$time, data, exp_wb_data[wb_idx]));
		else
			wb_idx++;
	endtask

	task automatic check_mem(
		input logic [cpu_pipe_pkg::WORD_W-1:0] addr,
		input logic [cpu_pipe_pkg::WORD_W-1:0] expected
	);
		logic [cpu_pipe_pkg::WORD_W-1:0] got;
		got = mem[addr[11:2]];
		if (got !== expected)
			abort_run($sformatf("mismatch at %0t: mem[%h] got %h expected %h",
				$time, addr, got, expected));
	endtask

	// debug outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n_i && dbg_wen !== '0)
			check_wb(dbg_wen, dbg_pc, dbg_wnum, dbg_wdata);
	end

	initial begin
		rst_n_i = 1'b0;
		wb_idx  = 0;
		cycles  = 0;
		read_vectors();
		limit = 20 * exp_wb_pc.size() + 100;
		repeat (2) @(posedge clk);
		#10 rst_n_i = 1'b1;
		while (wb_idx < exp_wb_pc.size() && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (wb_idx < exp_wb_pc.size()) begin
			abort_run($sformatf("timeout after %0d cycles, %0d of %0d writebacks seen",
				cycles, wb_idx, exp_wb_pc.size()));
		end else begin
			repeat (20) @(posedge clk); // extra writebacks would show here
			foreach (exp_mem_addr[i])
				check_mem(exp_mem_addr[i], exp_mem_data[i]);
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: source/openmips_core.sv
module openmips_core #(
	parameter logic [cpu_pipe_pkg::WORD_W-1:0] RESET_PC = '0
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic [cpu_pipe_pkg::WORD_W-1:0] mem_rdata_i,
	output logic                            mem_en_o,
	output logic [cpu_pipe_pkg::BE_W-1:0]   mem_wen_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] mem_addr_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] mem_wdata_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] debug_wb_pc_o,
	output logic [cpu_pipe_pkg::BE_W-1:0]   debug_wb_rf_wen_o,
	output logic [cpu_pipe_pkg::REG_AW-1:0] debug_wb_rf_wnum_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] debug_wb_rf_wdata_o
);
	logic                            hold;
	logic                            redirect;
	logic [cpu_pipe_pkg::WORD_W-1:0] target;
	logic                            if_valid;
	logic [cpu_pipe_pkg::WORD_W-1:0] if_instr;
	logic [cpu_pipe_pkg::WORD_W-1:0] if_pc;

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();
	reg_wr_if  ex_fwd ();
	reg_wr_if  mem_fwd ();
	reg_wr_if  wb ();
	exe_req_if exe ();
	mem_req_if memq ();

	assign debug_wb_pc_o       = wb.pc;
	assign debug_wb_rf_wen_o   = {cpu_pipe_pkg::BE_W{wb.we}};
	assign debug_wb_rf_wnum_o  = wb.waddr;
	assign debug_wb_rf_wdata_o = wb.wdata;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch_stage (
		.clk(clk), .rst_n_i(rst_n_i), .hold_i(hold), .redirect_i(redirect),
		.target_i(target), .fetch_bus(fetch_bus), .if_valid_o(if_valid),
		.if_instr_o(if_instr), .if_pc_o(if_pc)
	);

	decode_stage u_decode_stage (
		.clk(clk), .rst_n_i(rst_n_i), .if_valid_i(if_valid), .if_instr_i(if_instr),
		.if_pc_i(if_pc), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .wb(wb), .hold_o(hold),
		.redirect_o(redirect), .target_o(target), .exe(exe)
	);

	execute_stage u_execute_stage (
		.clk(clk), .rst_n_i(rst_n_i), .exe(exe), .ex_fwd(ex_fwd), .memq(memq)
	);

	memory_stage u_memory_stage (
		.clk(clk), .rst_n_i(rst_n_i), .memq(memq), .data_bus(data_bus),
		.mem_fwd(mem_fwd), .wb(wb)
	);

	bus_arbiter u_bus_arbiter (
		.fetch_bus(fetch_bus), .data_bus(data_bus), .mem_rdata_i(mem_rdata_i),
		.mem_en_o(mem_en_o), .mem_wen_o(mem_wen_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o)
	);

endmodule

// File: source/bus_arbiter.sv
module bus_arbiter (
	mem_bus_if.arb                          fetch_bus,
	mem_bus_if.arb                          data_bus,
	input  logic [cpu_pipe_pkg::WORD_W-1:0] mem_rdata_i,
	output logic                            mem_en_o,
	output logic [cpu_pipe_pkg::BE_W-1:0]   mem_wen_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] mem_addr_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] mem_wdata_o
);
	logic [cpu_pipe_pkg::BE_W-1:0] fetch_wen;
	logic [cpu_pipe_pkg::BE_W-1:0] data_wen;

	// fixed priority with data first
	assign data_bus.gnt  = data_bus.req;
	assign fetch_bus.gnt = fetch_bus.req && !data_bus.req;

	assign data_bus.rdata  = mem_rdata_i; // same-cycle read
	assign fetch_bus.rdata = mem_rdata_i;

	assign fetch_wen = fetch_bus.we ? fetch_bus.be : '0;
	assign data_wen  = data_bus.we ? data_bus.be : '0;

	assign mem_en_o    = data_bus.req || fetch_bus.req;
	assign mem_wen_o   = data_bus.req ? data_wen : fetch_wen;
	assign mem_addr_o  = data_bus.req ? data_bus.addr : fetch_bus.addr;
	assign mem_wdata_o = data_bus.req ? data_bus.wdata : fetch_bus.wdata;

	always_comb begin
		a_wen_with_en: assert final (mem_en_o || mem_wen_o == '0);
	end

endmodule

// File: source/memory_stage.sv
module memory_stage (
	input  logic       clk,
	input  logic       rst_n_i,
	mem_req_if.dst     memq,
	mem_bus_if.master  data_bus,
	reg_wr_if.src      mem_fwd,
	reg_wr_if.src      wb
);
	logic is_sb;
	logic is_load;

	assign is_sb   = memq.mem_op == cpu_pipe_pkg::MEM_SB;
	assign is_load = memq.mem_op == cpu_pipe_pkg::MEM_LW;

	// data always owns the port when it asks
	assign data_bus.req   = memq.valid && (memq.mem_op != cpu_pipe_pkg::MEM_NONE);
	assign data_bus.we    = (memq.mem_op == cpu_pipe_pkg::MEM_SW) || is_sb;
	assign data_bus.addr  = {memq.result[cpu_pipe_pkg::WORD_W-1:2], 2'b00};
	assign data_bus.be    = is_sb ? 4'b0001 << memq.result[1:0] : 4'b1111; // little-endian
	assign data_bus.wdata = is_sb ? {4{memq.store_data[7:0]}} : memq.store_data;

	assign mem_fwd.we    = memq.valid && memq.wreg;
	assign mem_fwd.waddr = memq.wd;
	assign mem_fwd.wdata = is_load ? data_bus.rdata : memq.result;
	assign mem_fwd.pc    = memq.pc;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			wb.we <= 1'b0;
		else
			wb.we <= mem_fwd.we;
	end

	always_ff @(posedge clk) begin
		wb.waddr <= mem_fwd.waddr;
		wb.wdata <= mem_fwd.wdata;
		wb.pc    <= mem_fwd.pc;
	end

	// stores never write a register
	a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
		data_bus.req && data_bus.we |-> !mem_fwd.we);

endmodule

// File: source/execute_stage.sv
module execute_stage (
	input  logic    clk,
	input  logic    rst_n_i,
	exe_req_if.dst  exe,
	reg_wr_if.src   ex_fwd,
	mem_req_if.src  memq
);
	logic [cpu_pipe_pkg::WORD_W-1:0] result;
	logic                            lt;

	assign lt = $signed(exe.src_a) < $signed(exe.src_b);

	// loads and stores reuse the adder for the address
	always_comb begin
		case (exe.alu_op)
			cpu_pipe_pkg::ALU_ADD:   result = exe.src_a + exe.src_b;
			cpu_pipe_pkg::ALU_SUB:   result = exe.src_a - exe.src_b;
			cpu_pipe_pkg::ALU_AND:   result = exe.src_a & exe.src_b;
			cpu_pipe_pkg::ALU_OR:    result = exe.src_a | exe.src_b;
			cpu_pipe_pkg::ALU_XOR:   result = exe.src_a ^ exe.src_b;
			cpu_pipe_pkg::ALU_SLT:   result = {{(cpu_pipe_pkg::WORD_W-1){1'b0}}, lt};
			cpu_pipe_pkg::ALU_PASSB: result = exe.src_b;
			default:                 result = '0;
		endcase
	end

	// a load's result is only an address here
	assign ex_fwd.we    = exe.valid && exe.wreg && (exe.mem_op != cpu_pipe_pkg::MEM_LW);
	assign ex_fwd.waddr = exe.wd;
	assign ex_fwd.wdata = result;
	assign ex_fwd.pc    = exe.pc;

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			memq.valid <= 1'b0;
		else
			memq.valid <= exe.valid;
	end

	always_ff @(posedge clk) begin
		memq.mem_op     <= exe.mem_op;
		memq.result     <= result;
		memq.store_data <= exe.store_data;
		memq.wd         <= exe.wd;
		memq.wreg       <= exe.wreg;
		memq.pc         <= exe.pc;
	end

endmodule

// File: source/decode_stage.sv
module decode_stage (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            if_valid_i,
	input  logic [cpu_pipe_pkg::WORD_W-1:0] if_instr_i,
	input  logic [cpu_pipe_pkg::WORD_W-1:0] if_pc_i,
	reg_wr_if.dst                           ex_fwd,
	reg_wr_if.dst                           mem_fwd,
	reg_wr_if.dst                           wb,
	output logic                            hold_o,
	output logic                            redirect_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] target_o,
	exe_req_if.src                          exe
);
	localparam int EXT_W = cpu_pipe_pkg::WORD_W - mips_isa_pkg::IMM_W;

	mips_isa_pkg::instr_u                instr;
	logic [cpu_pipe_pkg::WORD_W-1:0]     rf [cpu_pipe_pkg::REG_COUNT];
	logic [mips_isa_pkg::IMM_W-1:0]      imm;
	logic [cpu_pipe_pkg::REG_AW-1:0]     rs, rt, wd;
	logic [cpu_pipe_pkg::WORD_W-1:0]     opa, opb, imm_sx, imm_val, pc_plus4;
	logic [cpu_pipe_pkg::ALU_OP_W-1:0]   alu_op;
	logic [cpu_pipe_pkg::MEM_OP_W-1:0]   mem_op;
	logic                                use_imm, wreg, reads_rs, reads_rt;
	logic                                is_beq, is_bne, is_j, taken, ld_hazard;

	assign instr  = if_instr_i;
	assign rs     = instr.r_view.rs;
	assign rt     = instr.r_view.rt;
	assign imm    = instr.i_view.imm;
	assign imm_sx = {{EXT_W{imm[mips_isa_pkg::IMM_W-1]}}, imm};

	// newest producer wins and wb doubles as write-first bypass
	function automatic logic [cpu_pipe_pkg::WORD_W-1:0] read_opnd(
		input logic [cpu_pipe_pkg::REG_AW-1:0] a
	);
		if (a == '0)
			return '0;
		if (ex_fwd.we && ex_fwd.waddr == a)
			return ex_fwd.wdata;
		if (mem_fwd.we && mem_fwd.waddr == a)
			return mem_fwd.wdata;
		if (wb.we && wb.waddr == a)
			return wb.wdata;
		return rf[a];
	endfunction

	always_comb begin
		opa = read_opnd(rs);
		opb = read_opnd(rt);
	end

	always_comb begin
		alu_op   = cpu_pipe_pkg::ALU_ADD;
		mem_op   = cpu_pipe_pkg::MEM_NONE;
		imm_val  = imm_sx;
		use_imm  = 1'b1;
		wd       = rt;
		wreg     = 1'b0;
		reads_rs = 1'b1;
		reads_rt = 1'b0;
		is_beq   = 1'b0;
		is_bne   = 1'b0;
		is_j     = 1'b0;
		case (instr.r_view.opcode)
			mips_isa_pkg::OPC_SPECIAL: begin
				use_imm  = 1'b0;
				reads_rt = 1'b1;
				wd       = instr.r_view.rd;
				wreg     = 1'b1;
				case (instr.r_view.funct)
					mips_isa_pkg::FN_ADDU: alu_op = cpu_pipe_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUBU: alu_op = cpu_pipe_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  alu_op = cpu_pipe_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   alu_op = cpu_pipe_pkg::ALU_OR;
					mips_isa_pkg::FN_XOR:  alu_op = cpu_pipe_pkg::ALU_XOR;
					mips_isa_pkg::FN_SLT:  alu_op = cpu_pipe_pkg::ALU_SLT;
					default:               wreg = 1'b0; // nop and unsupported
				endcase
			end
			mips_isa_pkg::OPC_ADDIU: wreg = 1'b1;
			mips_isa_pkg::OPC_ORI: begin
				alu_op  = cpu_pipe_pkg::ALU_OR;
				imm_val = {{EXT_W{1'b0}}, imm};
				wreg    = 1'b1;
			end
			mips_isa_pkg::OPC_LUI: begin
				alu_op   = cpu_pipe_pkg::ALU_PASSB;
				imm_val  = {imm, {EXT_W{1'b0}}};
				wreg     = 1'b1;
				reads_rs = 1'b0;
			end
			mips_isa_pkg::OPC_LW: begin
				mem_op = cpu_pipe_pkg::MEM_LW;
				wreg   = 1'b1;
			end
			mips_isa_pkg::OPC_SW: begin
				mem_op   = cpu_pipe_pkg::MEM_SW;
				reads_rt = 1'b1;
			end
			mips_isa_pkg::OPC_SB: begin
				mem_op   = cpu_pipe_pkg::MEM_SB;
				reads_rt = 1'b1;
			end
			mips_isa_pkg::OPC_BEQ: begin
				is_beq   = 1'b1;
				reads_rt = 1'b1;
			end
			mips_isa_pkg::OPC_BNE: begin
				is_bne   = 1'b1;
				reads_rt = 1'b1;
			end
			mips_isa_pkg::OPC_J: begin
				is_j     = 1'b1;
				reads_rs = 1'b0;
			end
			default: reads_rs = 1'b0;
		endcase
	end

	// load in execute has no data yet
	assign ld_hazard = exe.valid && exe.wreg && (exe.mem_op == cpu_pipe_pkg::MEM_LW) &&
		((reads_rs && rs == exe.wd) || (reads_rt && rt == exe.wd));
	assign hold_o = if_valid_i && ld_hazard;

	assign pc_plus4   = if_pc_i + 32'd4;
	assign taken      = is_j || (is_beq && opa == opb) || (is_bne && opa != opb);
	assign redirect_o = if_valid_i && taken && !hold_o;
	assign target_o   = is_j ? {pc_plus4[31:28], if_instr_i[25:0], 2'b00}
		: pc_plus4 + {imm_sx[cpu_pipe_pkg::WORD_W-3:0], 2'b00};

	always_ff @(posedge clk) begin
		if (wb.we && wb.waddr != '0)
			rf[wb.waddr] <= wb.wdata;
	end

	// a stall leaves one bubble in decode/execute
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			exe.valid <= 1'b0;
		else
			exe.valid <= if_valid_i && !hold_o;
	end

	always_ff @(posedge clk) begin
		exe.alu_op     <= alu_op;
		exe.src_a      <= opa;
		exe.src_b      <= use_imm ? imm_val : opb;
		exe.store_data <= opb;
		exe.mem_op     <= mem_op;
		exe.wd         <= wd;
		exe.wreg       <= wreg && (wd != '0);
		exe.pc         <= if_pc_i;
	end

endmodule

// File: source/fetch_stage.sv
module fetch_stage #(
	parameter logic [cpu_pipe_pkg::WORD_W-1:0] RESET_PC = '0
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            hold_i,
	input  logic                            redirect_i,
	input  logic [cpu_pipe_pkg::WORD_W-1:0] target_i,
	mem_bus_if.master                       fetch_bus,
	output logic                            if_valid_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] if_instr_o,
	output logic [cpu_pipe_pkg::WORD_W-1:0] if_pc_o
);
	logic [cpu_pipe_pkg::WORD_W-1:0] pc_q;
	logic [cpu_pipe_pkg::WORD_W-1:0] pend_tgt_q;
	logic                            pend_q; // redirect waits for delay slot

	assign fetch_bus.req   = !hold_i;
	assign fetch_bus.we    = 1'b0;
	assign fetch_bus.be    = '0;
	assign fetch_bus.addr  = pc_q;
	assign fetch_bus.wdata = cpu_pipe_pkg::NOP_WORD;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q   <= RESET_PC;
			pend_q <= 1'b0;
		end else if (fetch_bus.gnt) begin
			// the word granted now is the delay slot when a redirect is around
			if (redirect_i)
				pc_q <= target_i;
			else if (pend_q)
				pc_q <= pend_tgt_q;
			else
				pc_q <= pc_q + 32'd4;
			pend_q <= 1'b0;
		end else if (redirect_i) begin
			pend_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_i && !fetch_bus.gnt)
			pend_tgt_q <= target_i;
	end

	// fetch/decode register, a lost fetch becomes a bubble
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			if_valid_o <= 1'b0;
		else if (!hold_i)
			if_valid_o <= fetch_bus.gnt;
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			if_instr_o <= fetch_bus.gnt ? fetch_bus.rdata : cpu_pipe_pkg::NOP_WORD;
			if_pc_o    <= pc_q;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		pc_q[1:0] == 2'b00);

endmodule

// File: source/core_ifs.sv
// one requester's view of the shared memory port
interface mem_bus_if;
	logic                              req;
	logic                              we;
	logic [cpu_pipe_pkg::BE_W-1:0]     be;
	logic [cpu_pipe_pkg::WORD_W-1:0]   addr;
	logic [cpu_pipe_pkg::WORD_W-1:0]   wdata;
	logic [cpu_pipe_pkg::WORD_W-1:0]   rdata; // valid in the granted cycle
	logic                              gnt;

	modport master (output req, we, be, addr, wdata, input rdata, gnt);
	modport arb (input req, we, be, addr, wdata, output rdata, gnt);
endinterface

// register write, used for forwarding and writeback
interface reg_wr_if;
	logic                              we;
	logic [cpu_pipe_pkg::REG_AW-1:0]   waddr;
	logic [cpu_pipe_pkg::WORD_W-1:0]   wdata;
	logic [cpu_pipe_pkg::WORD_W-1:0]   pc;

	modport src (output we, waddr, wdata, pc);
	modport dst (input we, waddr, wdata, pc);
endinterface

// decode/execute register contents
interface exe_req_if;
	logic                              valid;
	logic [cpu_pipe_pkg::ALU_OP_W-1:0] alu_op;
	logic [cpu_pipe_pkg::WORD_W-1:0]   src_a;
	logic [cpu_pipe_pkg::WORD_W-1:0]   src_b;
	logic [cpu_pipe_pkg::WORD_W-1:0]   store_data;
	logic [cpu_pipe_pkg::MEM_OP_W-1:0] mem_op;
	logic [cpu_pipe_pkg::REG_AW-1:0]   wd;
	logic                              wreg;
	logic [cpu_pipe_pkg::WORD_W-1:0]   pc;

	modport src (output valid, alu_op, src_a, src_b, store_data, mem_op, wd, wreg, pc);
	modport dst (input valid, alu_op, src_a, src_b, store_data, mem_op, wd, wreg, pc);
endinterface

// execute/memory register contents
interface mem_req_if;
	logic                              valid;
	logic [cpu_pipe_pkg::MEM_OP_W-1:0] mem_op;
	logic [cpu_pipe_pkg::WORD_W-1:0]   result; // alu result or address
	logic [cpu_pipe_pkg::WORD_W-1:0]   store_data;
	logic [cpu_pipe_pkg::REG_AW-1:0]   wd;
	logic                              wreg;
	logic [cpu_pipe_pkg::WORD_W-1:0]   pc;

	modport src (output valid, mem_op, result, store_data, wd, wreg, pc);
	modport dst (input valid, mem_op, result, store_data, wd, wreg, pc);
endinterface

// File: source/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	localparam int WORD_W    = 32;
	localparam int REG_AW    = 5;
	localparam int REG_COUNT = 32;
	localparam int BE_W      = 4;

	localparam int ALU_OP_W = 3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR   = 3'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT   = 3'd5;
	localparam logic [ALU_OP_W-1:0] ALU_PASSB = 3'd6; // lui path

	localparam int MEM_OP_W = 2;
	localparam logic [MEM_OP_W-1:0] MEM_NONE = 2'd0;
	localparam logic [MEM_OP_W-1:0] MEM_LW   = 2'd1;
	localparam logic [MEM_OP_W-1:0] MEM_SW   = 2'd2;
	localparam logic [MEM_OP_W-1:0] MEM_SB   = 2'd3;

	localparam logic [WORD_W-1:0] NOP_WORD = '0; // sll r0,r0,0

endpackage

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int OPC_W   = 6;
	localparam int FUNCT_W = 6;
	localparam int SHAMT_W = 5;
	localparam int IMM_W   = 16;

	// primary opcodes
	localparam logic [OPC_W-1:0] OPC_SPECIAL = 6'h00;
	localparam logic [OPC_W-1:0] OPC_J       = 6'h02;
	localparam logic [OPC_W-1:0] OPC_BEQ     = 6'h04;
	localparam logic [OPC_W-1:0] OPC_BNE     = 6'h05;
	localparam logic [OPC_W-1:0] OPC_ADDIU   = 6'h09;
	localparam logic [OPC_W-1:0] OPC_ORI     = 6'h0d;
	localparam logic [OPC_W-1:0] OPC_LUI     = 6'h0f;
	localparam logic [OPC_W-1:0] OPC_LW      = 6'h23;
	localparam logic [OPC_W-1:0] OPC_SB      = 6'h28;
	localparam logic [OPC_W-1:0] OPC_SW      = 6'h2b;

	// SPECIAL funct field
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;

	// one instruction word, R-format and I-format views
	typedef union packed {
		struct packed {
			logic [OPC_W-1:0]   opcode;
			logic [4:0]         rs;
			logic [4:0]         rt;
			logic [4:0]         rd;
			logic [SHAMT_W-1:0] shamt;
			logic [FUNCT_W-1:0] funct;
		} r_view;
		struct packed {
			logic [OPC_W-1:0] opcode;
			logic [4:0]       rs;
			logic [4:0]       rt;
			logic [IMM_W-1:0] imm;
		} i_view;
	} instr_u;

endpackage
